//--- hw/cache_pkg.sv
package cache_pkg;

    // geometry, direct mapped
    localparam int line_words = 4;
    localparam int num_lines  = 16;
    localparam int tag_bits   = 24;

    // bus length codes, beats minus one
    localparam logic [7:0] burst_len  = 8'd3;
    localparam logic [7:0] single_len = 8'd0;

    // fsm state codes shared by both caches
    localparam logic [2:0] st_idle   = 3'd0;
    localparam logic [2:0] st_lookup = 3'd1;
    localparam logic [2:0] st_wreq   = 3'd2;
    localparam logic [2:0] st_wdata  = 3'd3;
    localparam logic [2:0] st_wresp  = 3'd4;
    localparam logic [2:0] st_rreq   = 3'd5;
    localparam logic [2:0] st_rdata  = 3'd6;
    localparam logic [2:0] st_resp   = 3'd7;

    // byte address, flat or split for lookup
    typedef union packed {
        logic [31:0] flat;
        struct packed {
            logic [tag_bits-1:0] tag;
            logic [3:0]          index;
            logic [1:0]          word;
            logic [1:0]          byte_off;
        } fld;
    } cache_addr_t;

endpackage

//--- hw/mem_bus_if.sv
`timescale 1ns/1ps

interface mem_bus_if;
    // read channel
    logic        r_req;
    logic [31:0] r_addr;
    logic [7:0]  r_length;
    logic        r_rdy;
    logic        ret_valid;
    logic        ret_last;
    logic [31:0] r_data;
    // write channel
    logic        w_req;
    logic [31:0] w_addr;
    logic [7:0]  w_length;
    logic        w_rdy;
    logic        w_data_req;
    logic        w_last;
    logic [31:0] w_data;
    logic [3:0]  w_strb;
    logic        b_valid;
    logic        b_ready;

    modport master (
        output r_req, r_addr, r_length, w_req, w_addr, w_length,
        output w_data_req, w_last, w_data, w_strb, b_ready,
        input  r_rdy, ret_valid, ret_last, r_data, w_rdy, b_valid
    );

    modport slave (
        input  r_req, r_addr, r_length, w_req, w_addr, w_length,
        input  w_data_req, w_last, w_data, w_strb, b_ready,
        output r_rdy, ret_valid, ret_last, r_data, w_rdy, b_valid
    );
endinterface

//--- hw/dcache.sv
`timescale 1ns/1ps

module dcache
    import cache_pkg::*;
(
    input  logic        clk,
    input  logic        reset,
    input  logic        valid,
    input  logic        op,
    input  logic        uncache,
    input  cache_addr_t addr,
    input  logic [3:0]  wstrb,
    input  logic [31:0] wdata,
    output logic        cache_ready,
    output logic        data_valid,
    output logic [31:0] rdata,
    mem_bus_if.master   bus
);

    logic [2:0]           state;
    logic [2:0]           next_state;
    logic [1:0]           beat_cnt;

    // request buffer
    cache_addr_t          rq_addr;
    logic                 rq_op;
    logic                 rq_unc;
    logic [3:0]           rq_wstrb;
    logic [31:0]          rq_wdata;

    logic [tag_bits-1:0]  tag_mem [num_lines];
    logic [31:0]          data_mem [num_lines][line_words];
    logic [31:0]          ret_buf [line_words];
    logic [num_lines-1:0] valid_bits;
    logic [num_lines-1:0] dirty_bits;

    logic [3:0]           idx;
    logic                 hit;
    logic                 victim_dirty;
    logic [31:0]          word_addr;
    logic [31:0]          line_addr;
    logic [31:0]          victim_addr;

    function automatic logic [31:0] merge_bytes(input logic [31:0] old_word,
                                                input logic [31:0] new_word,
                                                input logic [3:0]  strb);
        logic [31:0] res;
        res = old_word;
        for (int i = 0; i < 4; i++) begin
            if (strb[i]) begin
                res[8*i +: 8] = new_word[8*i +: 8];
            end
        end
        return res;
    endfunction

    assign idx          = rq_addr.fld.index;
    assign hit          = valid_bits[idx] && (tag_mem[idx] == rq_addr.fld.tag) && !rq_unc;
    assign victim_dirty = valid_bits[idx] && dirty_bits[idx];
    assign word_addr    = {rq_addr.flat[31:2], 2'b00};
    assign line_addr    = {rq_addr.flat[31:4], 4'b0000};
    assign victim_addr  = {tag_mem[idx], idx, 4'b0000};

    // control fsm
    always_comb begin
        next_state = state;
        case (state)
            st_idle:   if (valid) next_state = st_lookup;
            st_lookup: begin
                if (rq_unc) begin
                    next_state = rq_op ? st_wreq : st_rreq;
                end else if (hit) begin
                    next_state = st_idle;
                end else begin
                    next_state = victim_dirty ? st_wreq : st_rreq;
                end
            end
            st_wreq:   if (bus.w_rdy) next_state = st_wdata;
            st_wdata:  if (bus.w_last) next_state = st_wresp;
            st_wresp:  if (bus.b_valid) next_state = rq_unc ? st_resp : st_rreq;
            st_rreq:   if (bus.r_rdy) next_state = st_rdata;
            st_rdata:  if (bus.ret_valid && bus.ret_last) next_state = st_resp;
            default:   next_state = st_idle;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state      <= st_idle;
            beat_cnt   <= '0;
            valid_bits <= '0;
            dirty_bits <= '0;
        end else begin
            state <= next_state;
            if (state == st_wreq || state == st_rreq) begin
                beat_cnt <= '0;
            end else if (state == st_wdata || (state == st_rdata && bus.ret_valid)) begin
                beat_cnt <= beat_cnt + 2'd1;
            end
            if (state == st_lookup && hit && rq_op) begin
                dirty_bits[idx] <= 1'b1;
            end
            // line install after refill
            if (state == st_resp && !rq_unc) begin
                valid_bits[idx] <= 1'b1;
                dirty_bits[idx] <= rq_op;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (state == st_idle && valid) begin
            rq_addr  <= addr;
            rq_op    <= op;
            rq_unc   <= uncache;
            rq_wstrb <= wstrb;
            rq_wdata <= wdata;
        end
        if (state == st_lookup && hit && rq_op) begin
            data_mem[idx][rq_addr.fld.word] <=
                merge_bytes(data_mem[idx][rq_addr.fld.word], rq_wdata, rq_wstrb);
        end
        // uncached word lands at its own slot
        if (state == st_rdata && bus.ret_valid) begin
            ret_buf[rq_unc ? rq_addr.fld.word : beat_cnt] <= bus.r_data;
        end
        if (state == st_resp && !rq_unc) begin
            tag_mem[idx] <= rq_addr.fld.tag;
            for (int w = 0; w < line_words; w++) begin
                if (rq_op && w == rq_addr.fld.word) begin
                    data_mem[idx][w] <= merge_bytes(ret_buf[w], rq_wdata, rq_wstrb);
                end else begin
                    data_mem[idx][w] <= ret_buf[w];
                end
            end
        end
    end

    assign cache_ready = (state == st_idle);
    assign data_valid  = (state == st_lookup && hit) || (state == st_resp);
    assign rdata       = (state == st_lookup) ? data_mem[idx][rq_addr.fld.word]
                                              : ret_buf[rq_addr.fld.word];

    assign bus.r_req      = (state == st_rreq);
    assign bus.r_addr     = rq_unc ? word_addr : line_addr;
    assign bus.r_length   = rq_unc ? single_len : burst_len;
    assign bus.w_req      = (state == st_wreq);
    assign bus.w_addr     = rq_unc ? word_addr : victim_addr;
    assign bus.w_length   = rq_unc ? single_len : burst_len;
    assign bus.w_data_req = (state == st_wdata);
    assign bus.w_last     = (state == st_wdata) && (rq_unc || beat_cnt == 2'd3);
    assign bus.w_data     = rq_unc ? rq_wdata : data_mem[idx][beat_cnt];
    assign bus.w_strb     = rq_unc ? rq_wstrb : 4'hf;
    assign bus.b_ready    = (state == st_wresp);

endmodule

//--- hw/icache.sv
`timescale 1ns/1ps

module icache
    import cache_pkg::*;
(
    input  logic        clk,
    input  logic        reset,
    input  logic        valid,
    input  cache_addr_t addr,
    output logic        cache_ready,
    output logic        data_valid,
    output logic [31:0] inst,
    mem_bus_if.master   bus
);

    logic [2:0]           state;
    logic [2:0]           next_state;
    logic [1:0]           beat_cnt;
    cache_addr_t          rq_addr;

    logic [tag_bits-1:0]  tag_mem [num_lines];
    logic [31:0]          data_mem [num_lines][line_words];
    logic [num_lines-1:0] valid_bits;

    logic [3:0]           idx;
    logic                 hit;

    assign idx = rq_addr.fld.index;
    assign hit = valid_bits[idx] && (tag_mem[idx] == rq_addr.fld.tag);

    // a filled line goes back through lookup and hits there
    always_comb begin
        next_state = state;
        case (state)
            st_idle:   if (valid) next_state = st_lookup;
            st_lookup: next_state = hit ? st_idle : st_rreq;
            st_rreq:   if (bus.r_rdy) next_state = st_rdata;
            st_rdata:  if (bus.ret_valid && bus.ret_last) next_state = st_lookup;
            default:   next_state = st_idle;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state      <= st_idle;
            beat_cnt   <= '0;
            valid_bits <= '0;
        end else begin
            state <= next_state;
            if (state == st_rreq) begin
                beat_cnt <= '0;
            end else if (state == st_rdata && bus.ret_valid) begin
                beat_cnt <= beat_cnt + 2'd1;
            end
            if (state == st_rdata && bus.ret_valid && bus.ret_last) begin
                valid_bits[idx] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (state == st_idle && valid) begin
            rq_addr <= addr;
        end
        // fill straight into the line array
        if (state == st_rdata && bus.ret_valid) begin
            data_mem[idx][beat_cnt] <= bus.r_data;
        end
        if (state == st_rdata && bus.ret_valid && bus.ret_last) begin
            tag_mem[idx] <= rq_addr.fld.tag;
        end
    end

    assign cache_ready = (state == st_idle);
    assign data_valid  = (state == st_lookup) && hit;
    assign inst        = data_mem[idx][rq_addr.fld.word];

    assign bus.r_req      = (state == st_rreq);
    assign bus.r_addr     = {rq_addr.flat[31:4], 4'b0000};
    assign bus.r_length   = burst_len;
    // read only, write channel idle
    assign bus.w_req      = 1'b0;
    assign bus.w_addr     = '0;
    assign bus.w_length   = '0;
    assign bus.w_data_req = 1'b0;
    assign bus.w_last     = 1'b0;
    assign bus.w_data     = '0;
    assign bus.w_strb     = '0;
    assign bus.b_ready    = 1'b0;

endmodule

//--- hw/mem_arbiter.sv
`timescale 1ns/1ps

module mem_arbiter (
    input  logic        clk,
    input  logic        reset,
    mem_bus_if.slave    d_bus,
    mem_bus_if.slave    i_bus,
    output logic        mem_r_req,
    output logic [31:0] mem_r_addr,
    output logic [7:0]  mem_r_length,
    input  logic        mem_r_rdy,
    input  logic        mem_ret_valid,
    input  logic        mem_ret_last,
    input  logic [31:0] mem_r_data,
    output logic        mem_w_req,
    output logic [31:0] mem_w_addr,
    output logic [7:0]  mem_w_length,
    input  logic        mem_w_rdy,
    output logic        mem_w_data_req,
    output logic        mem_w_last,
    output logic [31:0] mem_w_data,
    output logic [3:0]  mem_w_strb,
    input  logic        mem_b_valid,
    output logic        mem_b_ready
);

    logic busy;
    logic owner_d;
    logic wr_txn;
    logic d_want;
    logic i_want;
    logic use_d;
    logic use_i;
    logic done;

    assign d_want = d_bus.r_req | d_bus.w_req;
    assign i_want = i_bus.r_req | i_bus.w_req;
    assign use_d  = busy & owner_d;
    assign use_i  = busy & ~owner_d;
    assign done   = wr_txn ? mem_b_valid : (mem_ret_valid & mem_ret_last);

    // grant held for the whole transaction, dcache first
    always_ff @(posedge clk) begin
        if (reset) begin
            busy    <= 1'b0;
            owner_d <= 1'b0;
            wr_txn  <= 1'b0;
        end else if (!busy) begin
            if (d_want) begin
                busy    <= 1'b1;
                owner_d <= 1'b1;
                wr_txn  <= d_bus.w_req;
            end else if (i_want) begin
                busy    <= 1'b1;
                owner_d <= 1'b0;
                wr_txn  <= i_bus.w_req;
            end
        end else if (done) begin
            busy <= 1'b0;
        end
    end

    always_comb begin
        {mem_r_req, mem_r_addr, mem_r_length} = '0;
        {mem_w_req, mem_w_addr, mem_w_length} = '0;
        {mem_w_data_req, mem_w_last, mem_w_data, mem_w_strb, mem_b_ready} = '0;
        if (use_d) begin
            {mem_r_req, mem_r_addr, mem_r_length} = {d_bus.r_req, d_bus.r_addr, d_bus.r_length};
            {mem_w_req, mem_w_addr, mem_w_length} = {d_bus.w_req, d_bus.w_addr, d_bus.w_length};
            {mem_w_data_req, mem_w_last, mem_w_data, mem_w_strb, mem_b_ready} =
                {d_bus.w_data_req, d_bus.w_last, d_bus.w_data, d_bus.w_strb, d_bus.b_ready};
        end else if (use_i) begin
            {mem_r_req, mem_r_addr, mem_r_length} = {i_bus.r_req, i_bus.r_addr, i_bus.r_length};
            {mem_w_req, mem_w_addr, mem_w_length} = {i_bus.w_req, i_bus.w_addr, i_bus.w_length};
            {mem_w_data_req, mem_w_last, mem_w_data, mem_w_strb, mem_b_ready} =
                {i_bus.w_data_req, i_bus.w_last, i_bus.w_data, i_bus.w_strb, i_bus.b_ready};
        end
    end

    // strobes back to the owner only
    assign d_bus.r_rdy     = use_d & mem_r_rdy;
    assign d_bus.ret_valid = use_d & mem_ret_valid;
    assign d_bus.ret_last  = use_d & mem_ret_last;
    assign d_bus.r_data    = mem_r_data;
    assign d_bus.w_rdy     = use_d & mem_w_rdy;
    assign d_bus.b_valid   = use_d & mem_b_valid;
    assign i_bus.r_rdy     = use_i & mem_r_rdy;
    assign i_bus.ret_valid = use_i & mem_ret_valid;
    assign i_bus.ret_last  = use_i & mem_ret_last;
    assign i_bus.r_data    = mem_r_data;
    assign i_bus.w_rdy     = use_i & mem_w_rdy;
    assign i_bus.b_valid   = use_i & mem_b_valid;

endmodule

//--- hw/cache_top.sv
`timescale 1ns/1ps

module cache_top (
    input  logic        clk,
    input  logic        reset,
    // data side
    input  logic        d_valid,
    input  logic        d_op,
    input  logic        d_uncache,
    input  logic [31:0] d_addr,
    input  logic [3:0]  d_wstrb,
    input  logic [31:0] d_wdata,
    output logic        d_ready,
    output logic        d_data_valid,
    output logic [31:0] d_rdata,
    // fetch side
    input  logic        i_valid,
    input  logic [31:0] i_addr,
    output logic        i_ready,
    output logic        i_data_valid,
    output logic [31:0] i_inst,
    // memory bus
    output logic        mem_r_req,
    output logic [31:0] mem_r_addr,
    output logic [7:0]  mem_r_length,
    input  logic        mem_r_rdy,
    input  logic        mem_ret_valid,
    input  logic        mem_ret_last,
    input  logic [31:0] mem_r_data,
    output logic        mem_w_req,
    output logic [31:0] mem_w_addr,
    output logic [7:0]  mem_w_length,
    input  logic        mem_w_rdy,
    output logic        mem_w_data_req,
    output logic        mem_w_last,
    output logic [31:0] mem_w_data,
    output logic [3:0]  mem_w_strb,
    input  logic        mem_b_valid,
    output logic        mem_b_ready
);

    mem_bus_if d_bus_if ();
    mem_bus_if i_bus_if ();

    dcache dcache_i (
        .clk         (clk),
        .reset       (reset),
        .valid       (d_valid),
        .op          (d_op),
        .uncache     (d_uncache),
        .addr        (d_addr),
        .wstrb       (d_wstrb),
        .wdata       (d_wdata),
        .cache_ready (d_ready),
        .data_valid  (d_data_valid),
        .rdata       (d_rdata),
        .bus         (d_bus_if.master)
    );

    icache icache_i (
        .clk         (clk),
        .reset       (reset),
        .valid       (i_valid),
        .addr        (i_addr),
        .cache_ready (i_ready),
        .data_valid  (i_data_valid),
        .inst        (i_inst),
        .bus         (i_bus_if.master)
    );

    mem_arbiter arbiter_i (
        .clk            (clk),
        .reset          (reset),
        .d_bus          (d_bus_if.slave),
        .i_bus          (i_bus_if.slave),
        .mem_r_req      (mem_r_req),
        .mem_r_addr     (mem_r_addr),
        .mem_r_length   (mem_r_length),
        .mem_r_rdy      (mem_r_rdy),
        .mem_ret_valid  (mem_ret_valid),
        .mem_ret_last   (mem_ret_last),
        .mem_r_data     (mem_r_data),
        .mem_w_req      (mem_w_req),
        .mem_w_addr     (mem_w_addr),
        .mem_w_length   (mem_w_length),
        .mem_w_rdy      (mem_w_rdy),
        .mem_w_data_req (mem_w_data_req),
        .mem_w_last     (mem_w_last),
        .mem_w_data     (mem_w_data),
        .mem_w_strb     (mem_w_strb),
        .mem_b_valid    (mem_b_valid),
        .mem_b_ready    (mem_b_ready)
    );

endmodule

//--- tests/mem_model.sv
`timescale 1ns/1ps

module mem_model (
    input  logic        clk,
    input  logic        reset,
    input  logic        mem_r_req,
    input  logic [31:0] mem_r_addr,
    input  logic [7:0]  mem_r_length,
    output logic        mem_r_rdy,
    output logic        mem_ret_valid,
    output logic        mem_ret_last,
    output logic [31:0] mem_r_data,
    input  logic        mem_w_req,
    input  logic [31:0] mem_w_addr,
    input  logic [7:0]  mem_w_length,
    output logic        mem_w_rdy,
    input  logic        mem_w_data_req,
    input  logic        mem_w_last,
    input  logic [31:0] mem_w_data,
    input  logic [3:0]  mem_w_strb,
    output logic        mem_b_valid,
    input  logic        mem_b_ready
);

    logic [31:0] mem [1024];
    int          rd_count;
    int          wr_count;
    logic [7:0]  last_r_length;
    logic [7:0]  last_w_length;
    logic [31:0] last_w_addr;
    logic        overrun;
    logic        b_ready_miss;

    task automatic step();
        @(posedge clk);
        #1;
    endtask

    // random wait before a handshake
    task automatic idle_cycles();
        repeat ($urandom_range(0, 2)) step();
    endtask

    task automatic serve_read();
        logic [9:0] base;
        logic [7:0] len;
        base = mem_r_addr[11:2];
        len  = mem_r_length;
        idle_cycles();
        mem_r_rdy = 1'b1;
        step();
        mem_r_rdy = 1'b0;
        rd_count++;
        last_r_length = len;
        for (int b = 0; b <= len; b++) begin
            // occasional gap between beats
            if ($urandom_range(0, 3) == 0) begin
                step();
            end
            mem_ret_valid = 1'b1;
            mem_ret_last  = (b == len);
            mem_r_data    = mem[10'(base + b)];
            step();
            mem_ret_valid = 1'b0;
            mem_ret_last  = 1'b0;
        end
    endtask

    task automatic serve_write();
        logic [9:0]  base;
        logic [31:0] mask;
        logic        done;
        int          beat;
        base = mem_w_addr[11:2];
        last_w_addr   = mem_w_addr;
        last_w_length = mem_w_length;
        idle_cycles();
        mem_w_rdy = 1'b1;
        step();
        mem_w_rdy = 1'b0;
        wr_count++;
        beat = 0;
        done = 1'b0;
        // one beat taken per cycle
        for (int n = 0; n < 16 && !done; n++) begin
            if (mem_w_data_req) begin
                mask = {{8{mem_w_strb[3]}}, {8{mem_w_strb[2]}},
                        {8{mem_w_strb[1]}}, {8{mem_w_strb[0]}}};
                mem[10'(base + beat)] = (mem[10'(base + beat)] & ~mask) | (mem_w_data & mask);
                beat++;
                done = mem_w_last;
            end
            if (!done) begin
                step();
            end
        end
        if (!done) begin
            overrun = 1'b1;
            $display("memory model: write burst at %h never ended with w_last", last_w_addr);
        end
        step();
        idle_cycles();
        if (!mem_b_ready) begin
            b_ready_miss = 1'b1;
        end
        mem_b_valid = 1'b1;
        step();
        mem_b_valid = 1'b0;
    endtask

    initial begin
        for (int i = 0; i < 1024; i++) begin
            mem[i] = i ^ 32'h5a5a_0000;
        end
        mem_r_rdy     = 1'b0;
        mem_ret_valid = 1'b0;
        mem_ret_last  = 1'b0;
        mem_r_data    = '0;
        mem_w_rdy     = 1'b0;
        mem_b_valid   = 1'b0;
        rd_count      = 0;
        wr_count      = 0;
        last_r_length = '0;
        last_w_length = '0;
        last_w_addr   = '0;
        overrun       = 1'b0;
        b_ready_miss  = 1'b0;
        forever begin
            step();
            if (!reset && mem_r_req) begin
                serve_read();
            end else if (!reset && mem_w_req) begin
                serve_write();
            end
        end
    end

endmodule

//--- tests/cache_assertions.sv
`timescale 1ns/1ps

module cache_assertions (
    input logic        clk,
    input logic        reset,
    input logic        r_req,
    input logic        r_rdy,
    input logic [31:0] r_addr,
    input logic        w_data_req,
    input logic        w_last,
    input logic        d_req,
    input logic        i_req,
    input logic        d_rdy,
    input logic        i_rdy
);

    // read request stays up with a steady address until taken
    r_req_held: assert property (@(posedge clk) disable iff (reset)
        r_req && !r_rdy |=> r_req && $stable(r_addr))
        else $error("r_req dropped or r_addr changed before r_rdy");

    w_last_in_beat: assert property (@(posedge clk) disable iff (reset)
        w_last |-> w_data_req)
        else $error("w_last seen outside a write data beat");

    // ready strobes reach a single requesting master
    one_owner: assert property (@(posedge clk) disable iff (reset)
        !(d_rdy && i_rdy) && (!d_rdy || d_req) && (!i_rdy || i_req))
        else $error("ready strobe to both masters or to an idle master");

endmodule

bind mem_arbiter cache_assertions assertions_i (
    .clk        (clk),
    .reset      (reset),
    .r_req      (mem_r_req),
    .r_rdy      (mem_r_rdy),
    .r_addr     (mem_r_addr),
    .w_data_req (mem_w_data_req),
    .w_last     (mem_w_last),
    .d_req      (d_want),
    .i_req      (i_want),
    .d_rdy      (d_bus.r_rdy | d_bus.w_rdy),
    .i_rdy      (i_bus.r_rdy | i_bus.w_rdy)
);

//--- tests/cache_tb.sv
`timescale 1ns/1ps

module cache_tb
    import cache_pkg::*;
();

    localparam int wait_limit = 1000;

    logic        clk;
    logic        reset;
    logic        d_valid, d_op, d_uncache, d_ready, d_data_valid;
    logic [31:0] d_addr, d_wdata, d_rdata;
    logic [3:0]  d_wstrb;
    logic        i_valid, i_ready, i_data_valid;
    logic [31:0] i_addr, i_inst;
    logic        mem_r_req, mem_r_rdy, mem_ret_valid, mem_ret_last;
    logic [31:0] mem_r_addr, mem_r_data;
    logic [7:0]  mem_r_length, mem_w_length;
    logic        mem_w_req, mem_w_rdy, mem_w_data_req, mem_w_last, mem_b_valid, mem_b_ready;
    logic [31:0] mem_w_addr, mem_w_data;
    logic [3:0]  mem_w_strb;

    logic [31:0] shadow [1024];
    logic [32:0] d_exp_q [$];
    logic [32:0] i_exp_q [$];
    int          err_count;
    int          check_count;
    int          test_errs;
    int          d_lat;
    int          i_lat;
    int          cnt;
    logic [31:0] ra;

    cache_top dut_i (.*);
    mem_model mem_i (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic step();
        @(posedge clk);
        #1;
    endtask

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] exp);
        check_count++;
        if (got !== exp) begin
            err_count++;
            $display("** Error at %0t ns: %s, got %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic stop_on_timeout(input string what);
        $display("no %s within %0d cycles, run stopped", what, wait_limit);
        $display("TESTS FAILED");
        $finish;
    endtask

    // cpu view of memory with stores merged by byte strobe
    function automatic logic [31:0] ref_model(input logic wr, input cache_addr_t a,
                                              input logic [3:0] strb, input logic [31:0] wd);
        logic [9:0]  w;
        logic [31:0] mask;
        w    = {a.fld.tag[3:0], a.fld.index, a.fld.word};
        mask = {{8{strb[3]}}, {8{strb[2]}}, {8{strb[1]}}, {8{strb[0]}}};
        if (wr) begin
            shadow[w] = (shadow[w] & ~mask) | (wd & mask);
        end
        return shadow[w];
    endfunction

    task automatic d_access(input logic wr, input logic unc, input logic [31:0] a,
                            input logic [3:0] strb, input logic [31:0] wd);
        for (int n = 0; !d_ready && n < wait_limit; n++) begin
            step();
        end
        if (!d_ready) begin
            stop_on_timeout("d_ready");
        end
        d_exp_q.push_back({!wr, ref_model(wr, a, strb, wd)});
        d_valid   = 1'b1;
        d_op      = wr;
        d_uncache = unc;
        d_addr    = a;
        d_wstrb   = strb;
        d_wdata   = wd;
        step();
        d_valid = 1'b0;
        for (d_lat = 1; !d_data_valid && d_lat < wait_limit; d_lat++) begin
            step();
        end
        if (!d_data_valid) begin
            stop_on_timeout("d_data_valid");
        end
    endtask

    task automatic i_fetch(input logic [31:0] a);
        for (int n = 0; !i_ready && n < wait_limit; n++) begin
            step();
        end
        if (!i_ready) begin
            stop_on_timeout("i_ready");
        end
        i_exp_q.push_back({1'b1, ref_model(1'b0, a, 4'h0, 32'h0)});
        i_valid = 1'b1;
        i_addr  = a;
        step();
        i_valid = 1'b0;
        for (i_lat = 1; !i_data_valid && i_lat < wait_limit; i_lat++) begin
            step();
        end
        if (!i_data_valid) begin
            stop_on_timeout("i_data_valid");
        end
    endtask

    task automatic compare_result(input string what, input logic [31:0] got,
                                  ref logic [32:0] q [$]);
        logic [32:0] e;
        if (q.size() == 0) begin
            err_count++;
            $display("%s answered with no request outstanding", what);
        end else begin
            e = q.pop_front();
            if (e[32]) begin
                check_value(what, got, e[31:0]);
            end
        end
    endtask

    // every answer from either cache is checked here
    initial begin
        forever begin
            step();
            if (d_data_valid === 1'b1) begin
                compare_result("dcache load data", d_rdata, d_exp_q);
            end
            if (i_data_valid === 1'b1) begin
                compare_result("icache fetch data", i_inst, i_exp_q);
            end
        end
    end

    task automatic end_test(input string name);
        step();
        $display("%-40s %s", name, (err_count == test_errs) ? "ok" : "failed");
        test_errs = err_count;
    endtask

    initial begin
        void'($urandom(32'h0a1d_c413));
        err_count   = 0;
        check_count = 0;
        test_errs   = 0;
        reset     = 1'b1;
        d_valid   = 1'b0;
        d_op      = 1'b0;
        d_uncache = 1'b0;
        d_addr    = '0;
        d_wstrb   = '0;
        d_wdata   = '0;
        i_valid   = 1'b0;
        i_addr    = '0;
        for (int i = 0; i < 1024; i++) begin
            shadow[i] = i ^ 32'h5a5a_0000;
        end
        repeat (8) step();
        reset = 1'b0;

        d_access(1'b0, 1'b0, 32'h000, 4'h0, 32'h0);
        cnt = mem_i.rd_count;
        d_access(1'b0, 1'b0, 32'h004, 4'h0, 32'h0);
        check_value("dcache hit latency", d_lat, 1);
        check_value("line reads on a dcache hit", mem_i.rd_count, cnt);
        i_fetch(32'h800);
        i_fetch(32'h804);
        check_value("icache hit latency", i_lat, 1);
        end_test("loads after reset and hit timing");

        d_access(1'b1, 1'b0, 32'h008, 4'b0001, 32'h1111_11a1);
        d_access(1'b1, 1'b0, 32'h008, 4'b0110, 32'h22b2_c222);
        d_access(1'b1, 1'b0, 32'h008, 4'b1000, 32'hd333_3333);
        d_access(1'b0, 1'b0, 32'h008, 4'h0, 32'h0);
        // store miss merges into the refilled line
        d_access(1'b1, 1'b0, 32'h0a4, 4'b0011, 32'h4444_e5f6);
        d_access(1'b0, 1'b0, 32'h0a4, 4'h0, 32'h0);
        d_access(1'b0, 1'b0, 32'h0a0, 4'h0, 32'h0);
        end_test("byte strobed stores");

        d_access(1'b1, 1'b0, 32'h040, 4'b1111, 32'hcafe_0040);
        cnt = mem_i.wr_count;
        d_access(1'b0, 1'b0, 32'h140, 4'h0, 32'h0);
        check_value("victim write count", mem_i.wr_count, cnt + 1);
        check_value("victim write address", mem_i.last_w_addr, 32'h040);
        check_value("victim write length", mem_i.last_w_length, burst_len);
        for (int k = 16; k < 20; k++) begin
            check_value("memory after write-back", mem_i.mem[k], shadow[k]);
        end
        d_access(1'b0, 1'b0, 32'h040, 4'h0, 32'h0);
        end_test("dirty victim write-back");

        d_access(1'b0, 1'b1, 32'hc04, 4'h0, 32'h0);
        check_value("uncached read length", mem_i.last_r_length, single_len);
        d_access(1'b1, 1'b1, 32'hc08, 4'b1100, 32'hbeef_0000);
        check_value("uncached write length", mem_i.last_w_length, single_len);
        check_value("uncached store in memory", mem_i.mem[10'h302], shadow[10'h302]);
        d_access(1'b0, 1'b1, 32'hc08, 4'h0, 32'h0);
        end_test("uncached accesses");

        cnt = mem_i.rd_count;
        fork
            d_access(1'b0, 1'b0, 32'h300, 4'h0, 32'h0);
            i_fetch(32'h8c0);
        join
        check_value("line reads for two misses", mem_i.rd_count, cnt + 2);
        end_test("concurrent icache and dcache misses");

        for (int k = 0; k < 200; k++) begin
            ra = $urandom_range(0, 255) << 2;
            case ($urandom_range(0, 2))
                0:       d_access(1'b0, 1'b0, ra, 4'h0, 32'h0);
                1:       d_access(1'b1, 1'b0, ra, 4'($urandom_range(1, 15)), $urandom);
                default: i_fetch(32'h800 + (ra & 32'hff));
            endcase
        end
        end_test("random loads, stores and fetches");

        check_value("memory model write overrun", mem_i.overrun, 1'b0);
        check_value("b_valid sent while b_ready low", mem_i.b_ready_miss, 1'b0);
        check_value("dcache answers outstanding", d_exp_q.size(), 0);
        check_value("icache answers outstanding", i_exp_q.size(), 0);
        $display("checks: %0d, errors: %0d", check_count, err_count);
        if (err_count == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

//--- files.f
hw/cache_pkg.sv
hw/mem_bus_if.sv
hw/dcache.sv
hw/icache.sv
hw/mem_arbiter.sv
hw/cache_top.sv
tests/mem_model.sv
tests/cache_assertions.sv
tests/cache_tb.sv
